//--- rtl/csr_pkg.sv
`default_nettype none

package csr_pkg;

	localparam int xlen = 32;

	typedef logic [xlen-1:0] word_t;
	typedef logic [11:0] csr_addr_t;

	typedef enum logic [1:0]
	{
		priv_u = 2'b00,
		priv_s = 2'b01,
		priv_r = 2'b10, // reserved and never entered
		priv_m = 2'b11
	} priv_mode_t;

	// one trap bank per privilege level
	localparam csr_addr_t m_bank_base = 12'h300;
	localparam csr_addr_t s_bank_base = 12'h100;

	localparam csr_addr_t deleg_e_off = 12'h002;
	localparam csr_addr_t deleg_i_off = 12'h003;
	localparam csr_addr_t off_tvec    = 12'h005;
	localparam csr_addr_t off_scratch = 12'h040;
	localparam csr_addr_t off_epc     = 12'h041;
	localparam csr_addr_t off_cause   = 12'h042;
	localparam csr_addr_t off_tval    = 12'h043;

	// machine level
	localparam csr_addr_t csr_mstatus  = 12'h300;
	localparam csr_addr_t csr_misa     = 12'h301;
	localparam csr_addr_t csr_medeleg  = m_bank_base + deleg_e_off;
	localparam csr_addr_t csr_mideleg  = m_bank_base + deleg_i_off;
	localparam csr_addr_t csr_mie      = 12'h304;
	localparam csr_addr_t csr_mtvec    = m_bank_base + off_tvec;
	localparam csr_addr_t csr_mscratch = m_bank_base + off_scratch;
	localparam csr_addr_t csr_mepc     = m_bank_base + off_epc;
	localparam csr_addr_t csr_mcause   = m_bank_base + off_cause;
	localparam csr_addr_t csr_mtval    = m_bank_base + off_tval;
	localparam csr_addr_t csr_mip      = 12'h344;
	localparam csr_addr_t csr_mtimecmp = 12'hbbf; // custom slot

	// supervisor and shared
	localparam csr_addr_t csr_sstatus  = 12'h100;
	localparam csr_addr_t csr_sie      = 12'h104;
	localparam csr_addr_t csr_sip      = 12'h144;
	localparam csr_addr_t csr_stimecmp = 12'h5c0;
	localparam csr_addr_t csr_time     = 12'hc01;
	localparam csr_addr_t csr_timeh    = 12'hc81;

	// mxl=1 with extensions I M A S U
	localparam word_t misa_value = 32'h4014_1101;

	localparam word_t exc_i_addr_misaligned = 32'h0;

	// mstatus fields
	localparam int sie_bit  = 1;
	localparam int mie_bit  = 3;
	localparam int spie_bit = 5;
	localparam int mpie_bit = 7;
	localparam int spp_bit  = 8;
	localparam int mpp_lsb  = 11;
	localparam int sum_bit  = 18;

	// mie fields and the matching mip pending bits
	localparam int stie_bit = 5;
	localparam int mtie_bit = 7;
	localparam int seie_bit = 9;
	localparam int meie_bit = 11;

endpackage

`default_nettype wire

//--- rtl/csr_time_unit.sv
`timescale 1ns/10ps
`default_nettype none

module csr_time_unit
	import csr_pkg::*;
(
	input  logic        clk,
	input  logic        nrst,
	input  logic        csr_we,
	input  csr_addr_t   csr_address_wb,
	input  word_t       csr_wb,
	input  logic        exception_pending,
	output logic [63:0] mtime,
	output logic        m_timer,
	output logic        s_timer
);

	word_t mtimecmp;
	word_t stimecmp;

	// free running and cleared by any trap or return
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			mtime <= '0;
		else if (exception_pending)
			mtime <= '0;
		else
			mtime <= mtime + 64'd1;
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			mtimecmp <= '0;
			stimecmp <= '0;
		end
		else if (csr_we && !exception_pending)
		begin
			if (csr_address_wb == csr_mtimecmp)
				mtimecmp <= csr_wb;
			if (csr_address_wb == csr_stimecmp)
				stimecmp <= csr_wb;
		end
	end

	// flags lag the compare by one clock
	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			m_timer <= 1'b0;
			s_timer <= 1'b0;
		end
		else
		begin
			m_timer <= (mtime >= {32'b0, mtimecmp});
			s_timer <= (mtime >= {32'b0, stimecmp});
		end
	end

endmodule

`default_nettype wire

//--- rtl/csr_priv_ctrl.sv
`timescale 1ns/10ps
`default_nettype none

module csr_priv_ctrl
	import csr_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       exception_pending,
	input  logic       m_ret,
	input  logic       s_ret,
	input  word_t      cause,
	input  priv_mode_t mpp,
	input  logic       spp,
	input  word_t      medeleg,
	input  word_t      mideleg,
	output priv_mode_t current_mode,
	output logic       trap_to_m,
	output logic       trap_to_s,
	output logic       illegal_ret
);

	priv_mode_t next_mode;
	logic [4:0] code;
	logic deleg_hit;

	assign code = cause[4:0];
	assign deleg_hit = cause[xlen-1] ? mideleg[code] : medeleg[code]; // interrupt bit picks vector

	always_comb
	begin
		next_mode = current_mode;
		illegal_ret = 1'b0;
		trap_to_m = 1'b0;
		trap_to_s = 1'b0;
		if (exception_pending)
		begin
			if (m_ret)
			begin
				if (current_mode == priv_m)
					next_mode = mpp;
				else
					illegal_ret = 1'b1;
			end
			else if (s_ret)
			begin
				if (current_mode != priv_u)
					next_mode = spp ? priv_s : priv_u;
				else
					illegal_ret = 1'b1;
			end
			// traps from M never go down
			else if (current_mode != priv_m && deleg_hit)
			begin
				next_mode = priv_s;
				trap_to_s = 1'b1;
			end
			else
			begin
				next_mode = priv_m;
				trap_to_m = 1'b1;
			end
		end
	end

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
			current_mode <= priv_m; // hart starts in M
		else
			current_mode <= next_mode;
	end

endmodule

`default_nettype wire

//--- rtl/csr_status_regs.sv
`timescale 1ns/10ps
`default_nettype none

module csr_status_regs
	import csr_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       csr_we,
	input  csr_addr_t  csr_address_wb,
	input  word_t      csr_wb,
	input  logic       exception_pending,
	input  logic       trap_to_m,
	input  logic       trap_to_s,
	input  logic       m_ret,
	input  logic       s_ret,
	input  priv_mode_t current_mode,
	input  logic       m_interrupt,
	input  logic       s_interrupt,
	input  logic       m_timer,
	input  logic       s_timer,
	input  csr_addr_t  csr_address_r,
	output priv_mode_t mpp,
	output logic       spp,
	output word_t      rdata,
	output logic       hit,
	output logic       m_eie,
	output logic       m_tie,
	output logic       s_eie,
	output logic       s_tie
);

	logic status_sie, status_mie, status_spie, status_mpie, status_sum;
	logic meie, seie, mtie, stie;
	word_t mstatus_w, sstatus_w, mie_w, sie_w, mip_w, sip_w;
	priv_mode_t mpp_wr;

	assign mpp_wr = priv_mode_t'(csr_wb[mpp_lsb +: 2]);

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			status_sie <= 1'b0;
			status_mie <= 1'b0;
			status_spie <= 1'b0;
			status_mpie <= 1'b0;
			status_sum <= 1'b0;
			spp <= 1'b0;
			mpp <= priv_m;
			{meie, seie, mtie, stie} <= '0;
		end
		else if (exception_pending)
		begin
			if (trap_to_m)
			begin
				status_mpie <= status_mie; // push enable stack
				status_mie <= 1'b0;
				mpp <= current_mode;
			end
			else if (trap_to_s)
			begin
				status_spie <= status_sie;
				status_sie <= 1'b0;
				spp <= (current_mode == priv_s);
			end
			else if (m_ret && current_mode == priv_m)
			begin
				status_mie <= status_mpie;
				status_mpie <= 1'b1;
				mpp <= priv_u;
			end
			else if (s_ret && current_mode != priv_u)
			begin
				status_sie <= status_spie;
				status_spie <= 1'b1;
				spp <= 1'b0;
			end
		end
		else if (csr_we)
		begin
			case (csr_address_wb)
				csr_mstatus:
				begin
					status_sie <= csr_wb[sie_bit];
					status_mie <= csr_wb[mie_bit];
					status_spie <= csr_wb[spie_bit];
					status_mpie <= csr_wb[mpie_bit];
					status_sum <= csr_wb[sum_bit];
					spp <= csr_wb[spp_bit];
					if (mpp_wr != priv_r)
						mpp <= mpp_wr; // reserved value keeps the old mode
				end
				csr_sstatus:
				begin
					status_sie <= csr_wb[sie_bit];
					status_spie <= csr_wb[spie_bit];
					status_sum <= csr_wb[sum_bit];
					spp <= csr_wb[spp_bit];
				end
				csr_mie:
				begin
					stie <= csr_wb[stie_bit];
					mtie <= csr_wb[mtie_bit];
					seie <= csr_wb[seie_bit];
					meie <= csr_wb[meie_bit];
				end
				csr_sie:
				begin
					stie <= csr_wb[stie_bit];
					seie <= csr_wb[seie_bit];
				end
				default: ;
			endcase
		end
	end

	always_comb
	begin
		sstatus_w = '0;
		sstatus_w[sie_bit] = status_sie;
		sstatus_w[spie_bit] = status_spie;
		sstatus_w[spp_bit] = spp;
		sstatus_w[sum_bit] = status_sum;
		mstatus_w = sstatus_w; // sstatus is a subset
		mstatus_w[mie_bit] = status_mie;
		mstatus_w[mpie_bit] = status_mpie;
		mstatus_w[mpp_lsb +: 2] = mpp;
		sie_w = '0;
		sie_w[stie_bit] = stie;
		sie_w[seie_bit] = seie;
		mie_w = sie_w;
		mie_w[mtie_bit] = mtie;
		mie_w[meie_bit] = meie;
		sip_w = '0;
		sip_w[stie_bit] = s_timer;
		sip_w[seie_bit] = s_interrupt;
		mip_w = sip_w;
		mip_w[mtie_bit] = m_timer;
		mip_w[meie_bit] = m_interrupt;
	end

	always_comb
	begin
		hit = 1'b1;
		case (csr_address_r)
			csr_mstatus: rdata = mstatus_w;
			csr_sstatus: rdata = sstatus_w;
			csr_mie:     rdata = mie_w;
			csr_sie:     rdata = sie_w;
			csr_mip:     rdata = mip_w;
			csr_sip:     rdata = sip_w;
			default:
			begin
				rdata = '0;
				hit = 1'b0;
			end
		endcase
	end

	// enables gated by the global bit of their level
	assign m_eie = meie & status_mie;
	assign m_tie = mtie & status_mie;
	assign s_eie = seie & status_sie;
	assign s_tie = stie & status_sie;

endmodule

`default_nettype wire

//--- rtl/csr_trap_bank.sv
`timescale 1ns/10ps
`default_nettype none

module csr_trap_bank
	import csr_pkg::*;
#(
	parameter csr_addr_t bank_base = m_bank_base
)
(
	input  logic      clk,
	input  logic      nrst,
	input  logic      csr_we,
	input  csr_addr_t csr_address_wb,
	input  word_t     csr_wb,
	input  logic      exception_pending,
	input  logic      trap_take,
	input  word_t     cause,
	input  word_t     pc_exc,
	input  csr_addr_t csr_address_r,
	output word_t     rdata,
	output logic      hit,
	output word_t     tvec_addr,
	output word_t     epc_addr,
	output word_t     deleg_e,
	output word_t     deleg_i
);

	localparam csr_addr_t a_tvec    = bank_base + off_tvec;
	localparam csr_addr_t a_scratch = bank_base + off_scratch;
	localparam csr_addr_t a_epc     = bank_base + off_epc;
	localparam csr_addr_t a_cause   = bank_base + off_cause;
	localparam csr_addr_t a_tval    = bank_base + off_tval;
	localparam csr_addr_t a_deleg_e = bank_base + deleg_e_off;
	localparam csr_addr_t a_deleg_i = bank_base + deleg_i_off;

	logic [xlen-1:2] tvec; // direct mode only
	logic [xlen-1:2] epc;
	word_t xcause;
	word_t tval;
	word_t scratch;
	logic [15:0] edeleg;
	logic [11:0] ideleg;
	logic wr_en;

	assign wr_en = csr_we && !exception_pending;

	always_ff @(posedge clk, negedge nrst)
	begin
		if (!nrst)
		begin
			tvec <= '0;
			edeleg <= '0;
			ideleg <= '0;
		end
		else if (wr_en)
		begin
			if (csr_address_wb == a_tvec)
				tvec <= csr_wb[xlen-1:2];
			if (csr_address_wb == a_deleg_e)
				edeleg <= csr_wb[15:0];
			if (csr_address_wb == a_deleg_i)
				ideleg <= csr_wb[11:0];
		end
	end

	always_ff @(posedge clk)
	begin
		if (trap_take)
		begin
			epc <= pc_exc[xlen-1:2];
			xcause <= cause;
			// only a misaligned fetch reports an address
			if (cause == exc_i_addr_misaligned)
				tval <= {pc_exc[xlen-1:1], 1'b0};
			else
				tval <= '0;
		end
		else if (wr_en)
		begin
			case (csr_address_wb)
				a_epc:     epc <= csr_wb[xlen-1:2];
				a_cause:   xcause <= csr_wb;
				a_tval:    tval <= csr_wb;
				a_scratch: scratch <= csr_wb;
				default: ;
			endcase
		end
	end

	assign tvec_addr = {tvec, 2'b00};
	assign epc_addr = {epc, 2'b00};
	assign deleg_e = {16'b0, edeleg};
	assign deleg_i = {20'b0, ideleg};

	always_comb
	begin
		hit = 1'b1;
		case (csr_address_r)
			a_tvec:    rdata = tvec_addr;
			a_epc:     rdata = epc_addr;
			a_cause:   rdata = xcause;
			a_tval:    rdata = tval;
			a_scratch: rdata = scratch;
			a_deleg_e: rdata = deleg_e;
			a_deleg_i: rdata = deleg_i;
			default:
			begin
				rdata = '0;
				hit = 1'b0;
			end
		endcase
	end

endmodule

`default_nettype wire

//--- rtl/csr_output_mux.sv
`timescale 1ns/10ps
`default_nettype none

module csr_output_mux
	import csr_pkg::*;
(
	input  csr_addr_t   csr_address_r,
	input  logic [63:0] mtime,
	input  logic        st_hit,
	input  word_t       st_rdata,
	input  logic        m_hit,
	input  word_t       m_rdata,
	input  logic        s_hit,
	input  word_t       s_rdata,
	input  word_t       m_tvec,
	input  word_t       s_tvec,
	input  word_t       m_epc,
	input  word_t       s_epc,
	input  logic        m_ret,
	input  logic        s_ret,
	input  logic        trap_to_s,
	output word_t       csr_data,
	output word_t       epc
);

	word_t fixed_data;

	// read-only words held here
	always_comb
	begin
		case (csr_address_r)
			csr_misa:  fixed_data = misa_value;
			csr_time:  fixed_data = mtime[31:0];
			csr_timeh: fixed_data = mtime[63:32];
			default:   fixed_data = '0;
		endcase
	end

	// address ranges do not overlap, so a plain OR merges them
	assign csr_data = fixed_data
		| (st_hit ? st_rdata : '0)
		| (m_hit ? m_rdata : '0)
		| (s_hit ? s_rdata : '0);

	always_comb
	begin
		if (m_ret)
			epc = m_epc;
		else if (s_ret)
			epc = s_epc;
		else if (trap_to_s)
			epc = s_tvec; // delegated trap
		else
			epc = m_tvec;
	end

endmodule

`default_nettype wire

//--- rtl/csr_regfile.sv
`timescale 1ns/10ps
`default_nettype none

module csr_regfile
	import csr_pkg::*;
(
	input  logic       clk,
	input  logic       nrst,
	input  logic       csr_we,
	input  csr_addr_t  csr_address_r,
	input  csr_addr_t  csr_address_wb,
	input  word_t      csr_wb,
	input  logic       exception_pending,
	input  word_t      cause,
	input  word_t      pc_exc,
	input  logic       m_ret,
	input  logic       s_ret,
	input  logic       m_interrupt,
	input  logic       s_interrupt,
	output word_t      csr_data,
	output word_t      epc,
	output priv_mode_t current_mode,
	output logic       illegal_ret,
	output logic       m_timer,
	output logic       s_timer,
	output logic       m_eie,
	output logic       m_tie,
	output logic       s_eie,
	output logic       s_tie
);

	logic [63:0] mtime;
	priv_mode_t mpp;
	logic spp, trap_to_m, trap_to_s;
	word_t st_rdata, m_rdata, s_rdata;
	logic st_hit, m_hit, s_hit;
	word_t m_tvec, s_tvec, m_epc, s_epc;
	word_t medeleg, mideleg;

	csr_time_unit i_time_unit (
		.clk(clk), .nrst(nrst), .csr_we(csr_we), .csr_address_wb(csr_address_wb),
		.csr_wb(csr_wb), .exception_pending(exception_pending),
		.mtime(mtime), .m_timer(m_timer), .s_timer(s_timer)
	);

	csr_priv_ctrl i_priv_ctrl (
		.clk(clk), .nrst(nrst), .exception_pending(exception_pending),
		.m_ret(m_ret), .s_ret(s_ret), .cause(cause), .mpp(mpp), .spp(spp),
		.medeleg(medeleg), .mideleg(mideleg), .current_mode(current_mode),
		.trap_to_m(trap_to_m), .trap_to_s(trap_to_s), .illegal_ret(illegal_ret)
	);

	csr_status_regs i_status_regs (
		.clk(clk), .nrst(nrst), .csr_we(csr_we), .csr_address_wb(csr_address_wb),
		.csr_wb(csr_wb), .exception_pending(exception_pending),
		.trap_to_m(trap_to_m), .trap_to_s(trap_to_s), .m_ret(m_ret), .s_ret(s_ret),
		.current_mode(current_mode), .m_interrupt(m_interrupt),
		.s_interrupt(s_interrupt), .m_timer(m_timer), .s_timer(s_timer),
		.csr_address_r(csr_address_r), .mpp(mpp), .spp(spp),
		.rdata(st_rdata), .hit(st_hit),
		.m_eie(m_eie), .m_tie(m_tie), .s_eie(s_eie), .s_tie(s_tie)
	);

	csr_trap_bank #(.bank_base(m_bank_base)) i_m_bank (
		.clk(clk), .nrst(nrst), .csr_we(csr_we), .csr_address_wb(csr_address_wb),
		.csr_wb(csr_wb), .exception_pending(exception_pending), .trap_take(trap_to_m),
		.cause(cause), .pc_exc(pc_exc), .csr_address_r(csr_address_r),
		.rdata(m_rdata), .hit(m_hit), .tvec_addr(m_tvec), .epc_addr(m_epc),
		.deleg_e(medeleg), .deleg_i(mideleg)
	);

	// S level delegation vectors have no consumer
	csr_trap_bank #(.bank_base(s_bank_base)) i_s_bank (
		.clk(clk), .nrst(nrst), .csr_we(csr_we), .csr_address_wb(csr_address_wb),
		.csr_wb(csr_wb), .exception_pending(exception_pending), .trap_take(trap_to_s),
		.cause(cause), .pc_exc(pc_exc), .csr_address_r(csr_address_r),
		.rdata(s_rdata), .hit(s_hit), .tvec_addr(s_tvec), .epc_addr(s_epc),
		.deleg_e(), .deleg_i()
	);

	csr_output_mux i_output_mux (
		.csr_address_r(csr_address_r), .mtime(mtime),
		.st_hit(st_hit), .st_rdata(st_rdata), .m_hit(m_hit), .m_rdata(m_rdata),
		.s_hit(s_hit), .s_rdata(s_rdata), .m_tvec(m_tvec), .s_tvec(s_tvec),
		.m_epc(m_epc), .s_epc(s_epc), .m_ret(m_ret), .s_ret(s_ret),
		.trap_to_s(trap_to_s), .csr_data(csr_data), .epc(epc)
	);

endmodule

`default_nettype wire

//--- sim/csr_regfile_props.sv
`timescale 1ns/10ps
`default_nettype none

module csr_regfile_props
	import csr_pkg::*;
(
	input logic       clk,
	input logic       nrst,
	input logic       exception_pending,
	input logic       m_ret,
	input logic       s_ret,
	input logic       illegal_ret,
	input word_t      epc,
	input priv_mode_t current_mode,
	input logic       trap_to_m,
	input logic       trap_to_s,
	input logic       m_timer
);

	a_mode_legal: assert property (@(posedge clk) disable iff (!nrst)
		current_mode != priv_r)
		else $error("current_mode entered the reserved encoding");

	// return targets are always word aligned
	a_ret_aligned: assert property (@(posedge clk) disable iff (!nrst)
		(exception_pending && (m_ret || s_ret) && !illegal_ret) |-> epc[1:0] == 2'b00)
		else $error("return address not word aligned");

	a_one_target: assert property (@(posedge clk) disable iff (!nrst)
		!(trap_to_m && trap_to_s))
		else $error("trap sent to both levels");

	a_timer_in_reset: assert property (@(posedge clk) !nrst |-> !m_timer)
		else $error("m_timer high while in reset");

endmodule

`default_nettype wire

//--- sim/csr_regfile_tb.sv
`timescale 1ns/10ps
`default_nettype none

module csr_regfile_tb
	import csr_pkg::*;
();

	localparam int reset_cycles = 10;

	typedef enum logic [3:0]
	{
		op_write, op_read, op_trap, op_mret, op_sret,
		op_mode, op_flag, op_wait_timer, op_time
	} op_t;

	typedef struct packed
	{
		op_t       op;
		csr_addr_t addr; // flag select for op_flag
		word_t     data; // expected illegal_ret in bit 0 for returns
		word_t     cause;
		word_t     pc;
		word_t     expected;
	} step_t;

	logic clk, nrst, csr_we, exception_pending, m_ret, s_ret, m_interrupt, s_interrupt;
	csr_addr_t csr_address_r, csr_address_wb;
	word_t csr_wb, cause, pc_exc, csr_data, epc;
	priv_mode_t current_mode;
	logic illegal_ret, m_timer, s_timer, m_eie, m_tie, s_eie, s_tie;

	step_t steps[$];
	int num_steps = 0;
	int error_count = 0;
	word_t last_time = 32'h0;

	csr_regfile i_csr_regfile (
		.clk(clk), .nrst(nrst), .csr_we(csr_we), .csr_address_r(csr_address_r),
		.csr_address_wb(csr_address_wb), .csr_wb(csr_wb),
		.exception_pending(exception_pending), .cause(cause), .pc_exc(pc_exc),
		.m_ret(m_ret), .s_ret(s_ret), .m_interrupt(m_interrupt), .s_interrupt(s_interrupt),
		.csr_data(csr_data), .epc(epc), .current_mode(current_mode),
		.illegal_ret(illegal_ret), .m_timer(m_timer), .s_timer(s_timer),
		.m_eie(m_eie), .m_tie(m_tie), .s_eie(s_eie), .s_tie(s_tie)
	);

	bind csr_regfile csr_regfile_props i_props (
		.clk(clk), .nrst(nrst), .exception_pending(exception_pending),
		.m_ret(m_ret), .s_ret(s_ret), .illegal_ret(illegal_ret), .epc(epc),
		.current_mode(current_mode), .trap_to_m(trap_to_m), .trap_to_s(trap_to_s),
		.m_timer(m_timer)
	);

	initial
	begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	task automatic fail_run(input string msg);
		error_count++;
		$display("%s", msg);
		$display("ERRORS FOUND");
		$fatal(1, "stopped at first error");
	endtask

	task automatic check_word(input string name, input word_t actual, input word_t expected);
		if (actual !== expected)
			fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, actual, expected));
	endtask

	task automatic check_mode(input string name, input priv_mode_t actual,
		input priv_mode_t expected);
		if (actual !== expected)
			fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, actual, expected));
	endtask

	task automatic check_bit(input string name, input logic actual, input logic expected);
		if (actual !== expected)
			fail_run($sformatf("CHECK FAILED %s: got %h, expected %h", name, actual, expected));
	endtask

	task automatic add_step(input op_t op, input csr_addr_t addr, input word_t data,
		input word_t cause_v, input word_t pc, input word_t expected);
		step_t s;
		s.op = op;
		s.addr = addr;
		s.data = data;
		s.cause = cause_v;
		s.pc = pc;
		s.expected = expected;
		steps.push_back(s);
	endtask

	task automatic build_table();
		// reset state
		add_step(op_mode, 12'h000, 32'h0, 32'h0, 32'h0, 32'h3);
		add_step(op_read, csr_misa, 32'h0, 32'h0, 32'h0, 32'h4014_1101); // mxl 1 with I M A S U
		add_step(op_flag, 12'd0, 32'h0, 32'h0, 32'h0, 32'h0);
		add_step(op_flag, 12'd1, 32'h0, 32'h0, 32'h0, 32'h0);
		add_step(op_flag, 12'd2, 32'h0, 32'h0, 32'h0, 32'h0);
		add_step(op_flag, 12'd3, 32'h0, 32'h0, 32'h0, 32'h0);
		add_step(op_read, csr_mstatus, 32'h0, 32'h0, 32'h0, 32'h0000_1800); // mpp = M
		// plain writes and reads
		add_step(op_write, csr_mscratch, 32'hdead_beef, 32'h0, 32'h0, 32'h0);
		add_step(op_read, csr_mscratch, 32'h0, 32'h0, 32'h0, 32'hdead_beef);
		add_step(op_write, 12'h140, 32'h1234_5678, 32'h0, 32'h0, 32'h0); // sscratch
		add_step(op_read, 12'h140, 32'h0, 32'h0, 32'h0, 32'h1234_5678);
		add_step(op_write, csr_mtvec, 32'h8000_0103, 32'h0, 32'h0, 32'h0);
		add_step(op_read, csr_mtvec, 32'h0, 32'h0, 32'h0, 32'h8000_0100);
		add_step(op_write, csr_mepc, 32'h0000_2007, 32'h0, 32'h0, 32'h0);
		add_step(op_read, csr_mepc, 32'h0, 32'h0, 32'h0, 32'h0000_2004);
		add_step(op_write, csr_mstatus, 32'h0000_1922, 32'h0, 32'h0, 32'h0);
		add_step(op_read, csr_sstatus, 32'h0, 32'h0, 32'h0, 32'h0000_0122);
		add_step(op_read, csr_mstatus, 32'h0, 32'h0, 32'h0, 32'h0000_1922);
		// write riding on a trap strobe is dropped
		add_step(op_trap, 12'h140, 32'h0bad_0bad, 32'h5, 32'h3000, 32'h8000_0100);
		add_step(op_read, 12'h140, 32'h0, 32'h0, 32'h0, 32'h1234_5678);
		add_step(op_read, csr_mcause, 32'h0, 32'h0, 32'h0, 32'h5);
		add_step(op_read, csr_mtval, 32'h0, 32'h0, 32'h0, 32'h0);
		add_step(op_read, csr_mepc, 32'h0, 32'h0, 32'h0, 32'h3000);
		add_step(op_write, csr_mie, 32'h0000_0080, 32'h0, 32'h0, 32'h0);
		add_step(op_flag, 12'd0, 32'h0, 32'h0, 32'h0, 32'h0); // mie bit still low
		add_step(op_write, csr_mstatus, 32'h0000_1808, 32'h0, 32'h0, 32'h0);
		add_step(op_flag, 12'd0, 32'h0, 32'h0, 32'h0, 32'h1);
		add_step(op_read, csr_mie, 32'h0, 32'h0, 32'h0, 32'h0000_0080);
		// misaligned fetch in M
		add_step(op_trap, 12'h000, 32'h0, 32'h0, 32'h1003, 32'h8000_0100);
		add_step(op_read, csr_mepc, 32'h0, 32'h0, 32'h0, 32'h1000);
		add_step(op_read, csr_mtval, 32'h0, 32'h0, 32'h0, 32'h1002);
		add_step(op_read, csr_mcause, 32'h0, 32'h0, 32'h0, 32'h0);
		add_step(op_read, csr_mstatus, 32'h0, 32'h0, 32'h0, 32'h0000_1880);
		add_step(op_flag, 12'd0, 32'h0, 32'h0, 32'h0, 32'h0);
		add_step(op_mret, 12'h000, 32'h0, 32'h0, 32'h0, 32'h1000);
		add_step(op_mode, 12'h000, 32'h0, 32'h0, 32'h0, 32'h3);
		add_step(op_read, csr_mstatus, 32'h0, 32'h0, 32'h0, 32'h0000_0088);
		add_step(op_flag, 12'd0, 32'h0, 32'h0, 32'h0, 32'h1);
		// drop to S then delegate a trap
		add_step(op_write, csr_mstatus, 32'h0000_0800, 32'h0, 32'h0, 32'h0);
		add_step(op_mret, 12'h000, 32'h0, 32'h0, 32'h0, 32'h1000);
		add_step(op_mode, 12'h000, 32'h0, 32'h0, 32'h0, 32'h1);
		add_step(op_write, 12'h105, 32'h0000_4000, 32'h0, 32'h0, 32'h0); // stvec
		add_step(op_write, csr_medeleg, 32'h0000_0004, 32'h0, 32'h0, 32'h0);
		add_step(op_trap, 12'h000, 32'h0, 32'h2, 32'h5008, 32'h0000_4000);
		add_step(op_mode, 12'h000, 32'h0, 32'h0, 32'h0, 32'h1);
		add_step(op_read, 12'h141, 32'h0, 32'h0, 32'h0, 32'h5008); // sepc
		add_step(op_read, 12'h142, 32'h0, 32'h0, 32'h0, 32'h2); // scause
		add_step(op_read, csr_mepc, 32'h0, 32'h0, 32'h0, 32'h1000);
		add_step(op_read, csr_sstatus, 32'h0, 32'h0, 32'h0, 32'h0000_0100);
		add_step(op_write, csr_sstatus, 32'h0, 32'h0, 32'h0, 32'h0);
		add_step(op_sret, 12'h000, 32'h0, 32'h0, 32'h0, 32'h5008);
		add_step(op_mode, 12'h000, 32'h0, 32'h0, 32'h0, 32'h0);
		add_step(op_sret, 12'h000, 32'h1, 32'h0, 32'h0, 32'h5008); // illegal from U
		add_step(op_mode, 12'h000, 32'h0, 32'h0, 32'h0, 32'h0);
		// timer
		add_step(op_write, csr_mtimecmp, 32'd50, 32'h0, 32'h0, 32'h0);
		add_step(op_trap, 12'h000, 32'h0, 32'h3, 32'h6000, 32'h8000_0100);
		add_step(op_mode, 12'h000, 32'h0, 32'h0, 32'h0, 32'h3);
		add_step(op_flag, 12'd4, 32'h0, 32'h0, 32'h0, 32'h0);
		add_step(op_flag, 12'd5, 32'h0, 32'h0, 32'h0, 32'h1); // stimecmp still zero
		add_step(op_wait_timer, 12'h000, 32'h0, 32'h0, 32'h0, 32'h1);
		add_step(op_time, csr_time, 32'h0, 32'h0, 32'h0, 32'h0);
		add_step(op_time, csr_time, 32'h0, 32'h0, 32'h0, 32'h0);
	endtask

	task automatic apply_step(input step_t s);
		int cyc;
		@(posedge clk);
		csr_we <= 1'b0;
		exception_pending <= 1'b0;
		m_ret <= 1'b0;
		s_ret <= 1'b0;
		csr_address_r <= s.addr;
		csr_address_wb <= s.addr;
		csr_wb <= s.data;
		cause <= s.cause;
		pc_exc <= s.pc;
		case (s.op)
			op_write: csr_we <= 1'b1;
			op_trap:
			begin
				exception_pending <= 1'b1;
				csr_we <= (s.addr != 12'h000);
			end
			op_mret:
			begin
				exception_pending <= 1'b1;
				m_ret <= 1'b1;
			end
			op_sret:
			begin
				exception_pending <= 1'b1;
				s_ret <= 1'b1;
			end
			default: ;
		endcase
		@(negedge clk); // outputs settled here
		case (s.op)
			op_read: check_word("csr_data", csr_data, s.expected);
			op_trap: check_word("epc", epc, s.expected);
			op_mret, op_sret:
			begin
				check_word("epc", epc, s.expected);
				check_bit("illegal_ret", illegal_ret, s.data[0]);
			end
			op_mode: check_mode("current_mode", current_mode, priv_mode_t'(s.expected[1:0]));
			op_flag:
			begin
				case (s.addr)
					12'd0: check_bit("m_tie", m_tie, s.expected[0]);
					12'd1: check_bit("m_eie", m_eie, s.expected[0]);
					12'd2: check_bit("s_eie", s_eie, s.expected[0]);
					12'd3: check_bit("s_tie", s_tie, s.expected[0]);
					12'd4: check_bit("m_timer", m_timer, s.expected[0]);
					default: check_bit("s_timer", s_timer, s.expected[0]);
				endcase
			end
			op_wait_timer:
			begin
				for (cyc = 0; cyc < 60 && !m_timer; cyc++)
					@(negedge clk);
				if (!m_timer)
					fail_run("m_timer did not rise within 60 cycles of the counter clearing");
			end
			op_time:
			begin
				if (csr_data == 32'h0 || csr_data <= last_time)
					fail_run($sformatf("time read %h did not advance past %h", csr_data, last_time));
				last_time = csr_data;
			end
			default: ;
		endcase
	endtask

	// watchdog budget scales with the table length
	initial
	begin
		wait (num_steps > 0);
		repeat (reset_cycles + num_steps * 20) @(posedge clk);
		fail_run("simulation hung, watchdog ran out before the table finished");
	end

	initial
	begin
		nrst = 1'b0;
		csr_we = 1'b0;
		exception_pending = 1'b0;
		m_ret = 1'b0;
		s_ret = 1'b0;
		m_interrupt = 1'b0;
		s_interrupt = 1'b0;
		csr_address_r = 12'h000;
		csr_address_wb = 12'h000;
		csr_wb = 32'h0;
		cause = 32'h0;
		pc_exc = 32'h0;
		build_table();
		num_steps = steps.size();
		repeat (reset_cycles) @(posedge clk);
		nrst <= 1'b1;
		foreach (steps[i])
			apply_step(steps[i]);
		@(posedge clk);
		if (error_count == 0)
			$display("NO ERRORS");
		else
			$display("ERRORS FOUND");
		$finish;
	end

endmodule

`default_nettype wire

//--- tb.f
rtl/csr_pkg.sv
rtl/csr_time_unit.sv
rtl/csr_priv_ctrl.sv
rtl/csr_status_regs.sv
rtl/csr_trap_bank.sv
rtl/csr_output_mux.sv
rtl/csr_regfile.sv
sim/csr_regfile_props.sv
sim/csr_regfile_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build and run the CSR register file testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module csr_regfile_tb -f tb.f -Mdir obj_dir \
	|| { echo "build failed"; exit 1; }
./obj_dir/Vcsr_regfile_tb > sim.log 2>&1 ; cat sim.log
grep -q "ERRORS FOUND" sim.log && { echo "simulation failed"; exit 1; }
grep -q "NO ERRORS" sim.log && echo "simulation passed" || { echo "simulation did not finish"; exit 1; }
